/* core.f */
core_pkg.sv
fetch.sv
issue.sv
regfile.sv
decode.sv
execute.sv
core.sv
core_asserts.sv
core_checker.sv
core_tb.sv

/* core.sv */
`default_nettype none

module core (
	input wire clk,
	input wire arst_n,
	input wire imem_wait,
	input wire [core_pkg::XLEN-1:0] imem_data,
	output logic imem_req,
	output logic [core_pkg::IMEM_AW-1:0] imem_addr,
	output logic rf_write,
	output logic [core_pkg::REG_AW-1:0] rf_write_reg,
	output logic [core_pkg::XLEN-1:0] rf_write_data,
	output logic halted
);
	import core_pkg::*;

	logic bubble_1a;
	logic [XLEN-1:0] insn_1a;
	logic [IMEM_AW-1:0] pc_1a;
	logic stall_0a; // Issue holds fetch
	logic bubble_2a;
	logic [REG_AW-1:0] rf_read_0_1a;
	logic [REG_AW-1:0] rf_read_1_1a;
	logic [XLEN-1:0] rf_rdata_0_1a;
	logic [XLEN-1:0] rf_rdata_1_1a;
	opcode_t opc_2a;
	logic [REG_AW-1:0] rd_2a;
	logic [XLEN-1:0] op0_2a;
	logic [XLEN-1:0] op1_2a;
	logic [IMM_W-1:0] imm_2a;
	logic [IMEM_AW-1:0] pc_2a;
	logic pend_valid_2a;
	logic [REG_AW-1:0] pend_reg_2a;
	logic jmp_2a; // Taken branch, flushes 1a
	logic [IMEM_AW-1:0] jmppc_2a;
	logic halt_2a;

	fetch fetch_inst (
		.clk(clk), .arst_n(arst_n), .imem_wait(imem_wait), .imem_data(imem_data),
		.stall_0a(stall_0a), .jmp_2a(jmp_2a), .jmppc_2a(jmppc_2a), .halt_2a(halt_2a),
		.imem_req(imem_req), .imem_addr(imem_addr),
		.bubble_1a(bubble_1a), .insn_1a(insn_1a), .pc_1a(pc_1a)
	);

	issue issue_inst (
		.clk(clk), .arst_n(arst_n), .bubble_1a(bubble_1a), .insn_1a(insn_1a),
		.pend_valid_2a(pend_valid_2a), .pend_reg_2a(pend_reg_2a), .jmp_2a(jmp_2a),
		.stall_0a(stall_0a), .bubble_2a(bubble_2a)
	);

	regfile regfile_inst (
		.clk(clk), .arst_n(arst_n),
		.rf_read_0_1a(rf_read_0_1a), .rf_read_1_1a(rf_read_1_1a),
		.rf_write(rf_write), .rf_write_reg(rf_write_reg), .rf_write_data(rf_write_data),
		.rf_rdata_0_1a(rf_rdata_0_1a), .rf_rdata_1_1a(rf_rdata_1_1a)
	);

	decode decode_inst (
		.clk(clk), .insn_1a(insn_1a), .pc_1a(pc_1a), .stall_0a(stall_0a),
		.rf_rdata_0_1a(rf_rdata_0_1a), .rf_rdata_1_1a(rf_rdata_1_1a),
		.rf_read_0_1a(rf_read_0_1a), .rf_read_1_1a(rf_read_1_1a),
		.opc_2a(opc_2a), .rd_2a(rd_2a), .op0_2a(op0_2a), .op1_2a(op1_2a),
		.imm_2a(imm_2a), .pc_2a(pc_2a)
	);

	execute execute_inst (
		.clk(clk), .arst_n(arst_n), .bubble_2a(bubble_2a), .opc_2a(opc_2a),
		.rd_2a(rd_2a), .op0_2a(op0_2a), .op1_2a(op1_2a), .imm_2a(imm_2a), .pc_2a(pc_2a),
		.pend_valid_2a(pend_valid_2a), .pend_reg_2a(pend_reg_2a),
		.jmp_2a(jmp_2a), .jmppc_2a(jmppc_2a), .halt_2a(halt_2a),
		.rf_write(rf_write), .rf_write_reg(rf_write_reg), .rf_write_data(rf_write_data),
		.halted(halted)
	);

endmodule

`default_nettype wire

/* core_asserts.sv */
`default_nettype none

module core_asserts (
	input wire clk,
	input wire arst_n,
	input wire rf_write,
	input wire jmp_2a,
	input wire bubble_1a,
	input wire stall_0a
);

	// Retire strobe is cleared by the asynchronous reset
	assert property (@(posedge clk) !arst_n |-> !rf_write)
		else $error("rf_write seen while reset is asserted");

	// Redirect is a single-cycle pulse
	assert property (@(posedge clk) disable iff (!arst_n) jmp_2a |=> !jmp_2a)
		else $error("jmp_2a held for more than one cycle");

	// Held word is a real instruction, released after one cycle
	assert property (@(posedge clk) disable iff (!arst_n)
		stall_0a |=> !bubble_1a && !stall_0a)
		else $error("stall_0a did not hold a real instruction for exactly one cycle");

endmodule

bind core core_asserts core_asserts_inst (
	.clk(clk), .arst_n(arst_n), .rf_write(rf_write),
	.jmp_2a(jmp_2a), .bubble_1a(bubble_1a), .stall_0a(stall_0a)
);

`default_nettype wire

/* core_checker.sv */
`default_nettype none

module core_checker (
	input wire clk,
	input wire arst_n,
	input wire imem_req,
	input wire rf_write,
	input wire [core_pkg::REG_AW-1:0] rf_write_reg,
	input wire [core_pkg::XLEN-1:0] rf_write_data,
	input wire halted,
	input wire [16*core_pkg::XLEN-1:0] prog // Program words, unused slots hold HALT
);
	import core_pkg::*;

	int errors;
	int seen; // Writes observed in this test
	bit active;
	string name;
	logic [REG_AW-1:0] exp_reg [$];
	logic [XLEN-1:0] exp_data [$];

	// In-order instruction-set model, fills the expected write queues
	task automatic run_model();
		logic [XLEN-1:0] regs [16];
		logic [XLEN-1:0] w;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] sx;
		logic [XLEN-1:0] val;
		logic [IMEM_AW-1:0] pc;
		logic z;
		bit wr;
		bit done;
		int steps;
		for (int i = 0; i < 16; i++)
			regs[i] = '0;
		pc = '0;
		z = 1'b0;
		done = 0;
		steps = 0;
		exp_reg.delete();
		exp_data.delete();
		while (!done && steps < 1000) begin
			w = (pc < 16) ? prog[pc*XLEN +: XLEN] : {OP_HALT, 28'h0}; // Outside program
			a = regs[w[23:20]];
			b = regs[w[19:16]];
			sx = {{16{w[15]}}, w[15:0]};
			pc = pc + 8'd1; // Branches are relative to this
			steps++;
			wr = 1;
			val = '0;
			case (opcode_t'(w[31:28]))
				OP_ADD: val = a + b;
				OP_SUB: val = a - b;
				OP_AND: val = a & b;
				OP_ORR: val = a | b;
				OP_EOR: val = a ^ b;
				OP_MOVI: val = {16'h0, w[15:0]};
				OP_ADDI: val = a + sx;
				default: wr = 0; // CMP, branches, HALT and NOP write nothing
			endcase
			case (opcode_t'(w[31:28]))
				OP_CMP: z = (a == b);
				OP_B: pc = pc + sx[7:0];
				OP_BEQ: if (z) pc = pc + sx[7:0];
				OP_HALT: done = 1;
				default: ;
			endcase
			if (wr) begin
				exp_reg.push_back(w[27:24]);
				exp_data.push_back(val);
				regs[w[27:24]] = val; // Latest result into model state
			end
		end
	endtask

	task automatic start_test(input string tname, input int count);
		name = tname;
		run_model();
		if (exp_data.size() != count) begin
			$display("%s: model gives %0d writes but the table expects %0d",
				tname, exp_data.size(), count);
			errors++;
		end
		seen = 0;
		active = 1;
	endtask

	task automatic end_test();
		if (!halted) begin
			$display("%s: core never raised halted", name);
			errors++;
		end
		if (seen < exp_data.size()) begin
			$display("%s: %0d writes missing", name, exp_data.size() - seen);
			errors++;
		end
		active = 0;
	endtask

	initial begin
		errors = 0;
		seen = 0;
		active = 0;
	end

	// Outputs are settled at the falling edge
	always @(negedge clk) begin
		if (active && arst_n && halted && imem_req) begin
			$display("%s: fetch still requesting after halted", name);
			errors++;
		end
		if (active && arst_n && rf_write) begin
			if (halted) begin
				$display("%s: write to r%0d retired after halted", name, rf_write_reg);
				errors++;
			end else if (seen >= exp_data.size()) begin
				$display("%s: extra write to r%0d after the expected sequence",
					name, rf_write_reg);
				errors++;
			end else if (rf_write_reg != exp_reg[seen] || rf_write_data != exp_data[seen]) begin
				$display("FAIL %s write %0d: expected r%0d=%08h, actual r%0d=%08h", name, seen,
					exp_reg[seen], exp_data[seen], rf_write_reg, rf_write_data);
				errors++;
			end
			seen++;
		end
	end

endmodule

`default_nettype wire

/* core_pkg.sv */
`default_nettype none

package core_pkg;

	localparam int XLEN = 32; // Data and register width
	localparam int IMEM_AW = 8; // Instruction word address
	localparam int REG_AW = 4; // 16 registers

	// Instruction field positions
	localparam int OPC_LSB = 28;
	localparam int RD_LSB = 24; // Destination
	localparam int RN_LSB = 20; // First source
	localparam int RM_LSB = 16; // Second source
	localparam int IMM_W = 16; // Immediate in the low bits

	typedef enum logic [3:0] {
		OP_NOP = 4'd0,
		OP_ADD = 4'd1,
		OP_SUB = 4'd2,
		OP_AND = 4'd3,
		OP_ORR = 4'd4,
		OP_EOR = 4'd5,
		OP_MOVI = 4'd6, // Zero-extended immediate
		OP_ADDI = 4'd7, // rn plus sign-extended immediate
		OP_CMP = 4'd8, // Sets zero flag only
		OP_B = 4'd9, // pc + 1 + simm
		OP_BEQ = 4'd10, // Taken on zero flag
		OP_HALT = 4'd15
	} opcode_t;

endpackage

`default_nettype wire

/* core_tb.sv */
`default_nettype none

module core_tb;
	import core_pkg::*;

	localparam int NTESTS = 4;
	localparam int MAXLEN = 16;
	localparam int WAIT_PCT = 25; // Chance of imem_wait per cycle

	logic clk;
	logic arst_n;
	logic imem_wait;
	logic [XLEN-1:0] imem_data;
	logic imem_req;
	logic [IMEM_AW-1:0] imem_addr;
	logic rf_write;
	logic [REG_AW-1:0] rf_write_reg;
	logic [XLEN-1:0] rf_write_data;
	logic halted;

	logic [XLEN-1:0] mem [1 << IMEM_AW]; // Instruction memory model
	logic [16*XLEN-1:0] cur_prog;
	bit wait_en;
	string names [NTESTS];
	logic [XLEN-1:0] progs [NTESTS][MAXLEN];
	int prog_len [NTESTS];
	int exp_writes [NTESTS];
	int wd_cycles;

	core core_inst (
		.clk(clk), .arst_n(arst_n), .imem_wait(imem_wait), .imem_data(imem_data),
		.imem_req(imem_req), .imem_addr(imem_addr), .rf_write(rf_write),
		.rf_write_reg(rf_write_reg), .rf_write_data(rf_write_data), .halted(halted)
	);

	core_checker core_checker_inst (
		.clk(clk), .arst_n(arst_n), .imem_req(imem_req), .rf_write(rf_write),
		.rf_write_reg(rf_write_reg), .rf_write_data(rf_write_data), .halted(halted),
		.prog(cur_prog)
	);

	always #2 clk = !clk;

	// Data one cycle after an accepted request
	always @(posedge clk)
		if (imem_req && !imem_wait)
			imem_data <= mem[imem_addr];

	always @(negedge clk)
		imem_wait <= wait_en && (($urandom % 100) < WAIT_PCT);

	function automatic logic [XLEN-1:0] enc(input opcode_t op, input logic [3:0] rd,
		input logic [3:0] rn, input logic [3:0] rm, input logic [15:0] imm);
		return {op, rd, rn, rm, imm};
	endfunction

	function automatic logic [XLEN-1:0] fill_word(input int addr);
		return {OP_HALT, 20'h0, addr[7:0]}; // HALT tagged with its address
	endfunction

	task automatic add_word(input int t, input logic [XLEN-1:0] w);
		progs[t][prog_len[t]] = w;
		prog_len[t]++;
	endtask

	task automatic build_table();
		for (int t = 0; t < NTESTS; t++)
			prog_len[t] = 0;
		names[0] = "alu";
		exp_writes[0] = 8;
		add_word(0, enc(OP_MOVI, 4'd1, 4'd0, 4'd0, 16'h1234));
		add_word(0, enc(OP_MOVI, 4'd2, 4'd0, 4'd0, 16'h00f0));
		add_word(0, enc(OP_ADD, 4'd3, 4'd1, 4'd2, 16'h0));
		add_word(0, enc(OP_SUB, 4'd4, 4'd1, 4'd2, 16'h0));
		add_word(0, enc(OP_AND, 4'd5, 4'd1, 4'd2, 16'h0));
		add_word(0, enc(OP_ORR, 4'd6, 4'd1, 4'd2, 16'h0));
		add_word(0, enc(OP_EOR, 4'd7, 4'd1, 4'd2, 16'h0));
		add_word(0, enc(OP_ADDI, 4'd8, 4'd1, 4'd0, 16'hfffb)); // Minus five
		add_word(0, enc(OP_HALT, 4'd0, 4'd0, 4'd0, 16'h0));
		add_word(0, enc(OP_MOVI, 4'd9, 4'd0, 4'd0, 16'h0bad)); // Never retires
		names[1] = "chain";
		exp_writes[1] = 6;
		add_word(1, enc(OP_MOVI, 4'd1, 4'd0, 4'd0, 16'h0001));
		add_word(1, enc(OP_ADD, 4'd2, 4'd1, 4'd1, 16'h0));
		add_word(1, enc(OP_ADD, 4'd3, 4'd2, 4'd1, 16'h0));
		add_word(1, enc(OP_ADDI, 4'd4, 4'd3, 4'd0, 16'hffff));
		add_word(1, enc(OP_SUB, 4'd5, 4'd4, 4'd2, 16'h0));
		add_word(1, enc(OP_EOR, 4'd1, 4'd5, 4'd3, 16'h0));
		add_word(1, enc(OP_HALT, 4'd0, 4'd0, 4'd0, 16'h0));
		names[2] = "branch";
		exp_writes[2] = 4;
		add_word(2, enc(OP_MOVI, 4'd1, 4'd0, 4'd0, 16'h0005));
		add_word(2, enc(OP_B, 4'd0, 4'd0, 4'd0, 16'h0001));
		add_word(2, enc(OP_MOVI, 4'd2, 4'd0, 4'd0, 16'h0063)); // Skipped
		add_word(2, enc(OP_MOVI, 4'd3, 4'd0, 4'd0, 16'h0005));
		add_word(2, enc(OP_CMP, 4'd0, 4'd1, 4'd3, 16'h0));
		add_word(2, enc(OP_BEQ, 4'd0, 4'd0, 4'd0, 16'h0001)); // Taken
		add_word(2, enc(OP_MOVI, 4'd4, 4'd0, 4'd0, 16'h004d)); // Skipped
		add_word(2, enc(OP_CMP, 4'd0, 4'd1, 4'd2, 16'h0));
		add_word(2, enc(OP_BEQ, 4'd0, 4'd0, 4'd0, 16'h0001)); // Falls through
		add_word(2, enc(OP_MOVI, 4'd5, 4'd0, 4'd0, 16'h0008));
		add_word(2, enc(OP_MOVI, 4'd6, 4'd0, 4'd0, 16'h0009));
		add_word(2, enc(OP_HALT, 4'd0, 4'd0, 4'd0, 16'h0));
		names[3] = "loop";
		exp_writes[3] = 7;
		add_word(3, enc(OP_MOVI, 4'd1, 4'd0, 4'd0, 16'h0000));
		add_word(3, enc(OP_MOVI, 4'd2, 4'd0, 4'd0, 16'h0004));
		add_word(3, enc(OP_MOVI, 4'd3, 4'd0, 4'd0, 16'h0001));
		add_word(3, enc(OP_ADD, 4'd1, 4'd1, 4'd3, 16'h0));
		add_word(3, enc(OP_CMP, 4'd0, 4'd1, 4'd2, 16'h0));
		add_word(3, enc(OP_BEQ, 4'd0, 4'd0, 4'd0, 16'h0001)); // Exit to HALT
		add_word(3, enc(OP_B, 4'd0, 4'd0, 4'd0, 16'hfffc)); // Back to the ADD
		add_word(3, enc(OP_HALT, 4'd0, 4'd0, 4'd0, 16'h0));
		add_word(3, enc(OP_MOVI, 4'd9, 4'd0, 4'd0, 16'h0bad));
	endtask

	// Reset, load, run to halted, then watch a few more cycles
	task automatic run_test(input int t);
		int cyc;
		arst_n = 1'b0;
		for (int a = 0; a < (1 << IMEM_AW); a++)
			mem[a] = fill_word(a);
		for (int i = 0; i < MAXLEN; i++)
			cur_prog[i*XLEN +: XLEN] = (i < prog_len[t]) ? progs[t][i] : fill_word(i);
		for (int i = 0; i < prog_len[t]; i++)
			mem[i] = progs[t][i];
		repeat (2) @(posedge clk);
		core_checker_inst.start_test(wait_en ? {names[t], "_wait"} : names[t], exp_writes[t]);
		@(negedge clk);
		arst_n = 1'b1;
		cyc = 0;
		while (!halted && cyc < 40 * prog_len[t]) begin // Bounded per program word
			@(negedge clk);
			cyc++;
		end
		repeat (6) @(negedge clk); // Writes after HALT would show up here
		@(posedge clk);
		core_checker_inst.end_test();
		@(negedge clk);
	endtask

	initial begin
		clk = 1'b0;
		arst_n = 1'b0;
		imem_wait = 1'b0;
		imem_data = '0;
		wait_en = 0;
		cur_prog = '0;
		void'($urandom(6571));
		build_table();
		wd_cycles = 0;
		for (int t = 0; t < NTESTS; t++)
			wd_cycles += 2 * (40 * prog_len[t] + 20); // Both runs, reset and drain
		fork
			begin
				repeat (wd_cycles) @(posedge clk);
				$display("Watchdog expired after %0d cycles, core did not halt, errors %0d",
					wd_cycles, core_checker_inst.errors);
				$display("Errors found");
				$finish;
			end
		join_none
		@(negedge clk);
		for (int pass = 0; pass < 2; pass++) begin
			wait_en = (pass == 1); // Second pass with memory back-pressure
			for (int t = 0; t < NTESTS; t++)
				run_test(t);
		end
		$display("Tests run %0d, errors %0d", 2 * NTESTS, core_checker_inst.errors);
		if (core_checker_inst.errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* decode.sv */
`default_nettype none

module decode (
	input wire clk,
	input wire [core_pkg::XLEN-1:0] insn_1a,
	input wire [core_pkg::IMEM_AW-1:0] pc_1a,
	input wire stall_0a,
	input wire [core_pkg::XLEN-1:0] rf_rdata_0_1a,
	input wire [core_pkg::XLEN-1:0] rf_rdata_1_1a,
	output logic [core_pkg::REG_AW-1:0] rf_read_0_1a,
	output logic [core_pkg::REG_AW-1:0] rf_read_1_1a,
	output core_pkg::opcode_t opc_2a,
	output logic [core_pkg::REG_AW-1:0] rd_2a,
	output logic [core_pkg::XLEN-1:0] op0_2a,
	output logic [core_pkg::XLEN-1:0] op1_2a,
	output logic [core_pkg::IMM_W-1:0] imm_2a,
	output logic [core_pkg::IMEM_AW-1:0] pc_2a
);
	import core_pkg::*;

	opcode_t opc_1a;
	logic [REG_AW-1:0] rd_1a;
	logic [IMM_W-1:0] imm_1a;

	// Fixed fields, no format decoding needed
	assign opc_1a = opcode_t'(insn_1a[OPC_LSB +: $bits(opcode_t)]);
	assign rd_1a = insn_1a[RD_LSB +: REG_AW];
	assign imm_1a = insn_1a[IMM_W-1:0];

	// Sources always read, issue decides which ones matter
	assign rf_read_0_1a = insn_1a[RN_LSB +: REG_AW];
	assign rf_read_1_1a = insn_1a[RM_LSB +: REG_AW];

	// Pipeline register into execute, valid comes from issue
	always_ff @(posedge clk) begin
		if (!stall_0a) begin
			opc_2a <= opc_1a;
			rd_2a <= rd_1a;
			op0_2a <= rf_rdata_0_1a; // rn value, write-through included
			op1_2a <= rf_rdata_1_1a; // rm value
			imm_2a <= imm_1a;
			pc_2a <= pc_1a; // Base for branch target
		end
	end

endmodule

`default_nettype wire

/* execute.sv */
`default_nettype none

module execute (
	input wire clk,
	input wire arst_n,
	input wire bubble_2a,
	input core_pkg::opcode_t opc_2a,
	input wire [core_pkg::REG_AW-1:0] rd_2a,
	input wire [core_pkg::XLEN-1:0] op0_2a,
	input wire [core_pkg::XLEN-1:0] op1_2a,
	input wire [core_pkg::IMM_W-1:0] imm_2a,
	input wire [core_pkg::IMEM_AW-1:0] pc_2a,
	output logic pend_valid_2a,
	output logic [core_pkg::REG_AW-1:0] pend_reg_2a,
	output logic jmp_2a,
	output logic [core_pkg::IMEM_AW-1:0] jmppc_2a,
	output logic halt_2a,
	output logic rf_write,
	output logic [core_pkg::REG_AW-1:0] rf_write_reg,
	output logic [core_pkg::XLEN-1:0] rf_write_data,
	output logic halted
);
	import core_pkg::*;

	logic valid_2a; // Real instruction, not squashed by halt
	logic [XLEN-1:0] imm_sext;
	logic [XLEN-1:0] imm_zext;
	logic [XLEN-1:0] result_2a;
	logic writes_2a; // Opcode produces a register result
	logic zflag; // Set by the last CMP

	assign valid_2a = !bubble_2a && !halted; // Nothing after HALT takes effect
	assign imm_sext = {{(XLEN - IMM_W){imm_2a[IMM_W-1]}}, imm_2a};
	assign imm_zext = {{(XLEN - IMM_W){1'b0}}, imm_2a};

	always_comb begin
		writes_2a = 1'b1;
		result_2a = '0;
		case (opc_2a)
			OP_ADD: result_2a = op0_2a + op1_2a;
			OP_SUB: result_2a = op0_2a - op1_2a;
			OP_AND: result_2a = op0_2a & op1_2a;
			OP_ORR: result_2a = op0_2a | op1_2a;
			OP_EOR: result_2a = op0_2a ^ op1_2a;
			OP_MOVI: result_2a = imm_zext;
			OP_ADDI: result_2a = op0_2a + imm_sext; // Negative immediates allowed
			default: writes_2a = 1'b0; // CMP, branches, HALT, NOP
		endcase
	end

	// Destination still in flight, issue compares against it
	assign pend_valid_2a = valid_2a && writes_2a;
	assign pend_reg_2a = rd_2a;

	assign jmp_2a = valid_2a && ((opc_2a == OP_B) || ((opc_2a == OP_BEQ) && zflag));
	assign jmppc_2a = pc_2a + IMEM_AW'(1) + imm_2a[IMEM_AW-1:0]; // Wraps in word space
	assign halt_2a = valid_2a && (opc_2a == OP_HALT);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			zflag <= 1'b0;
			rf_write <= 1'b0;
			halted <= 1'b0;
		end else begin
			if (valid_2a && (opc_2a == OP_CMP))
				zflag <= (op0_2a == op1_2a); // Seen by a BEQ right behind
			rf_write <= pend_valid_2a; // Retire strobe in 3a
			if (halt_2a)
				halted <= 1'b1; // Sticky until reset
		end
	end

	// Retire payload, qualified by rf_write
	always_ff @(posedge clk) begin
		rf_write_reg <= rd_2a;
		rf_write_data <= result_2a;
	end

endmodule

`default_nettype wire

/* fetch.sv */
`default_nettype none

module fetch (
	input wire clk,
	input wire arst_n,
	input wire imem_wait,
	input wire [core_pkg::XLEN-1:0] imem_data,
	input wire stall_0a,
	input wire jmp_2a,
	input wire [core_pkg::IMEM_AW-1:0] jmppc_2a,
	input wire halt_2a,
	output logic imem_req,
	output logic [core_pkg::IMEM_AW-1:0] imem_addr,
	output logic bubble_1a,
	output logic [core_pkg::XLEN-1:0] insn_1a,
	output logic [core_pkg::IMEM_AW-1:0] pc_1a
);
	import core_pkg::*;

	logic [IMEM_AW-1:0] pc; // Address of the current request
	logic run_q; // Cleared once HALT reaches execute
	logic req_q; // Data of an accepted request arrives this cycle
	logic [IMEM_AW-1:0] req_pc; // Address of that request
	logic hold_q; // 1a word parked across a stall
	logic [XLEN-1:0] hold_insn;
	logic [IMEM_AW-1:0] hold_pc;
	logic accept_0a;

	assign imem_req = run_q && !halt_2a;
	assign imem_addr = pc;
	assign accept_0a = imem_req && !imem_wait && !stall_0a && !jmp_2a; // Flush or stall drops it

	assign insn_1a = hold_q ? hold_insn : imem_data;
	assign pc_1a = hold_q ? hold_pc : req_pc;
	assign bubble_1a = !(hold_q || req_q); // Wait or flush leaves a hole

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= '0;
			run_q <= 1'b1;
			req_q <= 1'b0;
			hold_q <= 1'b0;
		end else if (jmp_2a) begin
			pc <= jmppc_2a; // Redirect, next request at target
			req_q <= 1'b0; // Discard word in flight
			hold_q <= 1'b0;
		end else begin
			if (halt_2a)
				run_q <= 1'b0;
			if (accept_0a)
				pc <= pc + IMEM_AW'(1);
			req_q <= accept_0a;
			hold_q <= stall_0a; // Keep the 1a word while issue holds it
		end
	end

	always_ff @(posedge clk) begin
		if (accept_0a)
			req_pc <= pc;
		if (stall_0a) begin
			hold_insn <= insn_1a;
			hold_pc <= pc_1a;
		end
	end

endmodule

`default_nettype wire

/* issue.sv */
`default_nettype none

module issue (
	input wire clk,
	input wire arst_n,
	input wire bubble_1a,
	input wire [core_pkg::XLEN-1:0] insn_1a,
	input wire pend_valid_2a,
	input wire [core_pkg::REG_AW-1:0] pend_reg_2a,
	input wire jmp_2a,
	output logic stall_0a,
	output logic bubble_2a
);
	import core_pkg::*;

	opcode_t opc_1a;
	logic [REG_AW-1:0] rn_1a;
	logic [REG_AW-1:0] rm_1a;
	logic use_rn; // Opcode reads the first source
	logic use_rm; // Opcode reads the second source
	logic hit_rn;
	logic hit_rm;

	assign opc_1a = opcode_t'(insn_1a[OPC_LSB +: $bits(opcode_t)]);
	assign rn_1a = insn_1a[RN_LSB +: REG_AW];
	assign rm_1a = insn_1a[RM_LSB +: REG_AW];

	always_comb begin
		use_rn = 1'b0;
		use_rm = 1'b0;
		case (opc_1a)
			OP_ADD, OP_SUB, OP_AND, OP_ORR, OP_EOR, OP_CMP: begin
				use_rn = 1'b1; // Register-register forms
				use_rm = 1'b1;
			end
			OP_ADDI: use_rn = 1'b1;
			default: ; // MOVI, branches, HALT and NOP read nothing
		endcase
	end

	assign hit_rn = use_rn && (rn_1a == pend_reg_2a);
	assign hit_rm = use_rm && (rm_1a == pend_reg_2a);

	// One cycle is enough, the result is written through next cycle
	assign stall_0a = !bubble_1a && pend_valid_2a && (hit_rn || hit_rm);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			bubble_2a <= 1'b1;
		else
			bubble_2a <= bubble_1a || stall_0a || jmp_2a; // Bubble on hole, stall or flush
	end

endmodule

`default_nettype wire

/* regfile.sv */
`default_nettype none

module regfile (
	input wire clk,
	input wire arst_n,
	input wire [core_pkg::REG_AW-1:0] rf_read_0_1a,
	input wire [core_pkg::REG_AW-1:0] rf_read_1_1a,
	input wire rf_write,
	input wire [core_pkg::REG_AW-1:0] rf_write_reg,
	input wire [core_pkg::XLEN-1:0] rf_write_data,
	output logic [core_pkg::XLEN-1:0] rf_rdata_0_1a,
	output logic [core_pkg::XLEN-1:0] rf_rdata_1_1a
);
	import core_pkg::*;

	logic [XLEN-1:0] regs [1 << REG_AW];

	// Read with bypass of the write retiring this cycle
	function automatic logic [XLEN-1:0] read_port(input logic [REG_AW-1:0] num);
		if (rf_write && (rf_write_reg == num))
			return rf_write_data;
		return regs[num];
	endfunction

	assign rf_rdata_0_1a = read_port(rf_read_0_1a);
	assign rf_rdata_1_1a = read_port(rf_read_1_1a);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < (1 << REG_AW); i++)
				regs[i] <= '0; // All registers start at zero
		end else if (rf_write) begin
			regs[rf_write_reg] <= rf_write_data;
		end
	end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the core testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert --top-module core_tb -f core.f -o core_sim \
	> build.log 2>&1 &&
./obj_dir/core_sim > sim.log 2>&1 ||
echo "Build or simulation did not complete, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -qx "No errors" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
